// File: logic/soc_pkg.sv
// SoC shared definitions
package soc_pkg;

	// Bus widths
	localparam int ARCH_W = 32;
	localparam int SEL_W = ARCH_W / 8;
	localparam int ADDR_W = ARCH_W - $clog2(SEL_W);

	// Bus op codes
	typedef logic [1:0] op_t;
	localparam op_t OP_NOOP = 2'd0;
	localparam op_t OP_WR = 2'd1;
	localparam op_t OP_RD = 2'd2;
	// Swap returns the old word and writes the new one
	localparam op_t OP_RW = 2'd3;

	// Address map in words
	localparam logic [ADDR_W-1:0] RAM_BASE = 30'd0;
	localparam logic [ADDR_W-1:0] RAM_WORDS = 30'd1024;
	localparam logic [ADDR_W-1:0] DEVTBL_BASE = 30'd1024;
	localparam logic [ADDR_W-1:0] DEVTBL_WORDS = 30'd64;
	// Only reported in the device table
	localparam logic [ADDR_W-1:0] INVALID_WORDS = 30'd1024;

	// Slave indices
	typedef logic [1:0] slv_idx_t;
	localparam slv_idx_t SLV_RAM = 2'd0;
	localparam slv_idx_t SLV_DEVTBL = 2'd1;
	localparam slv_idx_t SLV_INVALID = 2'd2;
	localparam slv_idx_t SLV_COUNT = 2'd3;

	// Device ids
	localparam int DEV_ID_W = 16;
	localparam logic [DEV_ID_W-1:0] RAM_ID = 16'd1;
	localparam logic [DEV_ID_W-1:0] DEVTBL_ID = 16'd7;
	localparam logic [DEV_ID_W-1:0] INVALID_ID = 16'd0;

	localparam logic [ARCH_W-1:0] SOC_ID = 32'd5;

	// Device table entry layout
	typedef struct packed {
		logic [DEV_ID_W-1:0] id;
		logic [14:0] rsvd;
		logic useintr;
	} devtbl_entry_t;

	// Table word read as a raw value or as an entry
	typedef union packed {
		logic [ARCH_W-1:0] raw;
		devtbl_entry_t ent;
	} devtbl_word_u;

endpackage

// File: logic/pi1_if.sv
// PI1 bus interface
`timescale 1ns/1ps

interface pi1_if;

	soc_pkg::op_t op;
	logic [soc_pkg::ADDR_W-1:0] addr;
	logic [soc_pkg::ARCH_W-1:0] wdata;
	logic [soc_pkg::SEL_W-1:0] sel;
	logic [soc_pkg::ARCH_W-1:0] rdata;
	logic rdy;

	// Fabric side
	modport master (
		output op, addr, wdata, sel,
		input rdata, rdy
	);

	// Device side
	modport slave (
		input op, addr, wdata, sel,
		output rdata, rdy
	);

endinterface

// File: logic/soc_rst_ctrl.sv
// Reset sequencer
`timescale 1ns/1ps

module soc_rst_ctrl #(
	parameter int RST_CNTR_BITSZ = 16
) (
	input logic clk48mhz_i,
	input logic rst_p,
	input logic rst0_i,
	input logic rst1_i,
	output logic sys_rst_o,
	output logic pwroff_o
);

	logic [RST_CNTR_BITSZ-1:0] rst_cntr;
	logic pwroff_q;
	logic sw_cold;
	logic sw_warm;
	logic sw_pwroff;

	// Request decode from the device table pulses
	assign sw_cold = rst0_i & rst1_i;
	assign sw_warm = ~rst0_i & rst1_i;
	assign sw_pwroff = rst0_i & ~rst1_i;

	// Cold and warm requests both restart the sequence
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p || sw_cold || sw_warm) begin
			rst_cntr <= '1;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off holds until the external reset
	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cntr != '0) | pwroff_q;
	assign pwroff_o = pwroff_q;

endmodule

// File: logic/pi1_fabric.sv
// PI1 bus fabric
`timescale 1ns/1ps

module pi1_fabric (
	input logic clk48mhz_i,
	input logic sys_rst_i,
	input soc_pkg::op_t op_i,
	input logic [soc_pkg::ADDR_W-1:0] addr_i,
	input logic [soc_pkg::ARCH_W-1:0] data_i,
	input logic [soc_pkg::SEL_W-1:0] sel_i,
	output logic [soc_pkg::ARCH_W-1:0] data_o,
	output logic rdy_o,
	pi1_if.master ram_bus,
	pi1_if.master devtbl_bus
);

	soc_pkg::slv_idx_t slv_idx;
	soc_pkg::slv_idx_t rsp_idx;
	logic [soc_pkg::ADDR_W-1:0] ram_off;
	logic [soc_pkg::ADDR_W-1:0] devtbl_off;
	logic slv_rdy;
	logic accept;
	logic accept_rd;

	// Offsets wrap below the base, so one compare covers the range
	assign ram_off = addr_i - soc_pkg::RAM_BASE;
	assign devtbl_off = addr_i - soc_pkg::DEVTBL_BASE;

	always_comb begin
		if (ram_off < soc_pkg::RAM_WORDS) begin
			slv_idx = soc_pkg::SLV_RAM;
		end else if (devtbl_off < soc_pkg::DEVTBL_WORDS) begin
			slv_idx = soc_pkg::SLV_DEVTBL;
		end else begin
			slv_idx = soc_pkg::SLV_INVALID;
		end
	end

	// Ready level of the addressed slave
	always_comb begin
		case (slv_idx)
			soc_pkg::SLV_RAM: slv_rdy = ram_bus.rdy;
			soc_pkg::SLV_DEVTBL: slv_rdy = devtbl_bus.rdy;
			default: slv_rdy = 1'b1;
		endcase
	end

	assign rdy_o = slv_rdy & ~sys_rst_i;
	assign accept = rdy_o & (op_i != soc_pkg::OP_NOOP);
	assign accept_rd = accept & ((op_i == soc_pkg::OP_RD) | (op_i == soc_pkg::OP_RW));

	// Only the addressed slave sees the op
	assign ram_bus.op = (accept && slv_idx == soc_pkg::SLV_RAM) ? op_i : soc_pkg::OP_NOOP;
	assign ram_bus.addr = addr_i;
	assign ram_bus.wdata = data_i;
	assign ram_bus.sel = sel_i;

	assign devtbl_bus.op = (accept && slv_idx == soc_pkg::SLV_DEVTBL) ?
		op_i : soc_pkg::OP_NOOP;
	assign devtbl_bus.addr = addr_i;
	assign devtbl_bus.wdata = data_i;
	assign devtbl_bus.sel = sel_i;

	// Remember who answers the last accepted read
	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			rsp_idx <= soc_pkg::SLV_INVALID;
		end else if (accept_rd) begin
			rsp_idx <= slv_idx;
		end
	end

	// Invalid device reads as zero and drops writes
	always_comb begin
		case (rsp_idx)
			soc_pkg::SLV_RAM: data_o = ram_bus.rdata;
			soc_pkg::SLV_DEVTBL: data_o = devtbl_bus.rdata;
			default: data_o = '0;
		endcase
	end

endmodule

// File: logic/soc_ram.sv
// On-chip RAM slave
`timescale 1ns/1ps

module soc_ram (
	input logic clk48mhz_i,
	pi1_if.slave bus
);

	localparam int RAM_AW = $clog2(soc_pkg::RAM_WORDS);

	logic [soc_pkg::ARCH_W-1:0] mem [soc_pkg::RAM_WORDS];
	logic [soc_pkg::ARCH_W-1:0] rdata_q;
	logic [soc_pkg::ADDR_W-1:0] offset;
	logic [RAM_AW-1:0] word_idx;
	logic do_rd;
	logic do_wr;

	assign offset = bus.addr - soc_pkg::RAM_BASE;
	assign word_idx = offset[RAM_AW-1:0];

	// Swap does both and the read sees the old word
	assign do_rd = (bus.op == soc_pkg::OP_RD) | (bus.op == soc_pkg::OP_RW);
	assign do_wr = (bus.op == soc_pkg::OP_WR) | (bus.op == soc_pkg::OP_RW);

	always_ff @(posedge clk48mhz_i) begin
		if (do_rd) begin
			rdata_q <= mem[word_idx];
		end
		if (do_wr) begin
			for (int b = 0; b < soc_pkg::SEL_W; b++) begin
				if (bus.sel[b]) begin
					mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
				end
			end
		end
	end

	assign bus.rdata = rdata_q;
	// Single-cycle access that never stalls
	assign bus.rdy = 1'b1;

endmodule

// File: logic/soc_devtbl.sv
// Device table slave
`timescale 1ns/1ps

module soc_devtbl (
	input logic clk48mhz_i,
	input logic sys_rst_i,
	pi1_if.slave bus,
	output logic rst0_o,
	output logic rst1_o
);

	localparam int TBL_AW = $clog2(soc_pkg::DEVTBL_WORDS);

	// Per-slave id and map size in slave index order
	localparam logic [soc_pkg::DEV_ID_W-1:0] DEV_IDS [soc_pkg::SLV_COUNT] = '{
		soc_pkg::RAM_ID, soc_pkg::DEVTBL_ID, soc_pkg::INVALID_ID
	};
	localparam logic [soc_pkg::ADDR_W-1:0] MAP_WORDS [soc_pkg::SLV_COUNT] = '{
		soc_pkg::RAM_WORDS, soc_pkg::DEVTBL_WORDS, soc_pkg::INVALID_WORDS
	};

	logic [soc_pkg::ADDR_W-1:0] full_off;
	logic [TBL_AW-1:0] off;
	logic [TBL_AW-1:0] slot;
	soc_pkg::slv_idx_t k;
	soc_pkg::devtbl_word_u rd_word;
	logic [soc_pkg::ARCH_W-1:0] rdata_q;
	logic do_rd;
	logic ctl_wr;

	assign full_off = bus.addr - soc_pkg::DEVTBL_BASE;
	assign off = full_off[TBL_AW-1:0];

	// Two words per slave starting at offset 2
	assign slot = off - TBL_AW'(2);
	assign k = slot[2:1];

	always_comb begin
		rd_word.raw = '0;
		if (off == '0) begin
			rd_word.raw = soc_pkg::SOC_ID;
		end else if (off == TBL_AW'(1)) begin
			rd_word.raw = soc_pkg::ARCH_W'(soc_pkg::SLV_COUNT);
		end else if (off < TBL_AW'(2 + 2 * soc_pkg::SLV_COUNT)) begin
			if (!off[0]) begin
				rd_word.ent.id = DEV_IDS[k];
				// No interrupt controller in this SoC
				rd_word.ent.useintr = 1'b0;
			end else begin
				rd_word.raw = soc_pkg::ARCH_W'(MAP_WORDS[k]);
			end
		end
	end

	assign do_rd = (bus.op == soc_pkg::OP_RD) | (bus.op == soc_pkg::OP_RW);
	assign ctl_wr = ((bus.op == soc_pkg::OP_WR) | (bus.op == soc_pkg::OP_RW)) & (off == '0);

	always_ff @(posedge clk48mhz_i) begin
		if (do_rd) begin
			rdata_q <= rd_word.raw;
		end
	end

	// Reset request pulses last one cycle
	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			rst0_o <= 1'b0;
			rst1_o <= 1'b0;
		end else begin
			rst0_o <= ctl_wr & bus.wdata[0];
			rst1_o <= ctl_wr & bus.wdata[1];
		end
	end

	assign bus.rdata = rdata_q;
	assign bus.rdy = 1'b1;

endmodule

// File: logic/soc_top.sv
// SoC system bus top level
`timescale 1ns/1ps

module soc_top #(
	parameter int RST_CNTR_BITSZ = 4
) (
	input logic clk48mhz_i,
	input logic rst_p,

	// Bus master side
	input soc_pkg::op_t pi1_op_i,
	input logic [soc_pkg::ADDR_W-1:0] pi1_addr_i,
	input logic [soc_pkg::ARCH_W-1:0] pi1_data_i,
	input logic [soc_pkg::SEL_W-1:0] pi1_sel_i,
	output logic [soc_pkg::ARCH_W-1:0] pi1_data_o,
	output logic pi1_rdy_o,

	output logic sys_rst_o,
	output logic pwroff_o
);

	logic devtbl_rst0;
	logic devtbl_rst1;

	pi1_if ram_bus ();
	pi1_if devtbl_bus ();

	soc_rst_ctrl #(
		.RST_CNTR_BITSZ(RST_CNTR_BITSZ)
	) u_rst_ctrl (
		.clk48mhz_i(clk48mhz_i),
		.rst_p(rst_p),
		.rst0_i(devtbl_rst0),
		.rst1_i(devtbl_rst1),
		.sys_rst_o(sys_rst_o),
		.pwroff_o(pwroff_o)
	);

	pi1_fabric u_fabric (
		.clk48mhz_i(clk48mhz_i),
		.sys_rst_i(sys_rst_o),
		.op_i(pi1_op_i),
		.addr_i(pi1_addr_i),
		.data_i(pi1_data_i),
		.sel_i(pi1_sel_i),
		.data_o(pi1_data_o),
		.rdy_o(pi1_rdy_o),
		.ram_bus(ram_bus.master),
		.devtbl_bus(devtbl_bus.master)
	);

	// RAM contents survive every reset
	soc_ram u_ram (
		.clk48mhz_i(clk48mhz_i),
		.bus(ram_bus.slave)
	);

	soc_devtbl u_devtbl (
		.clk48mhz_i(clk48mhz_i),
		.sys_rst_i(sys_rst_o),
		.bus(devtbl_bus.slave),
		.rst0_o(devtbl_rst0),
		.rst1_o(devtbl_rst1)
	);

endmodule

// File: sim/tb_vectors.svh
// Bus stimulus table
// Columns are op, word address, write data, byte selects, expected read word,
// random write data flag, check kind and test number
localparam int NUM_VECTORS = 36;
localparam vec_t VECTORS [NUM_VECTORS] = '{
	// Full RAM words first so no byte stays unknown
	'{soc_pkg::OP_WR, 30'd3, 32'h0, 4'hf, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_WR, 30'd4, 32'h0, 4'hf, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_WR, 30'd1023, 32'h0, 4'hf, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_WR, 30'd5, 32'h0, 4'hf, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_WR, 30'd3, 32'h0, 4'h5, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_WR, 30'd4, 32'h0, 4'h8, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_WR, 30'd1023, 32'h0, 4'h6, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_RD, 30'd3, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd2},
	'{soc_pkg::OP_RD, 30'd4, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd2},
	'{soc_pkg::OP_RD, 30'd1023, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd2},
	'{soc_pkg::OP_RD, 30'd5, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd2},
	'{soc_pkg::OP_WR, 30'd5, 32'h0, 4'h3, 32'h0, 1'b1, CHK_NONE, 3'd2},
	'{soc_pkg::OP_RD, 30'd5, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd2},
	// Swap returns the old word
	'{soc_pkg::OP_RW, 30'd4, 32'h0, 4'hf, 32'h0, 1'b1, CHK_MODEL, 3'd3},
	'{soc_pkg::OP_RD, 30'd4, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd3},
	'{soc_pkg::OP_RW, 30'd3, 32'h0, 4'h9, 32'h0, 1'b1, CHK_MODEL, 3'd3},
	'{soc_pkg::OP_RW, 30'd3, 32'h0, 4'h2, 32'h0, 1'b1, CHK_MODEL, 3'd3},
	'{soc_pkg::OP_RD, 30'd3, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd3},
	// Device table entries carry the id in the upper half
	'{soc_pkg::OP_RD, 30'd1024, 32'h0, 4'hf, 32'd5, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1025, 32'h0, 4'hf, 32'd3, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1026, 32'h0, 4'hf, 32'h0001_0000, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1027, 32'h0, 4'hf, 32'd1024, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1028, 32'h0, 4'hf, 32'h0007_0000, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1029, 32'h0, 4'hf, 32'd64, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1030, 32'h0, 4'hf, 32'h0, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1031, 32'h0, 4'hf, 32'd1024, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1032, 32'h0, 4'hf, 32'h0, 1'b0, CHK_FIXED, 3'd4},
	'{soc_pkg::OP_RD, 30'd1087, 32'h0, 4'hf, 32'h0, 1'b0, CHK_FIXED, 3'd4},
	// Word 2053 lies outside the map but shares its low bits with RAM word 5
	'{soc_pkg::OP_WR, 30'd1088, 32'h0, 4'hf, 32'h0, 1'b1, CHK_NONE, 3'd5},
	'{soc_pkg::OP_RD, 30'd1088, 32'h0, 4'hf, 32'h0, 1'b0, CHK_FIXED, 3'd5},
	'{soc_pkg::OP_WR, 30'd2053, 32'h0, 4'hf, 32'h0, 1'b1, CHK_NONE, 3'd5},
	'{soc_pkg::OP_RD, 30'd2053, 32'h0, 4'hf, 32'h0, 1'b0, CHK_FIXED, 3'd5},
	'{soc_pkg::OP_WR, 30'h3fff_ffff, 32'h0, 4'hf, 32'h0, 1'b1, CHK_NONE, 3'd5},
	'{soc_pkg::OP_RD, 30'h3fff_ffff, 32'h0, 4'hf, 32'h0, 1'b0, CHK_FIXED, 3'd5},
	'{soc_pkg::OP_RD, 30'd5, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd5},
	'{soc_pkg::OP_RD, 30'd1023, 32'h0, 4'hf, 32'h0, 1'b0, CHK_MODEL, 3'd5}
};

// File: sim/tb_soc_top.sv
// SoC bus testbench
`timescale 1ns/1ps

module tb_soc_top;

	localparam int RST_CYCLES = 15;
	localparam int WAIT_LIMIT = 200;
	localparam logic [1:0] CHK_NONE = 2'd0;
	localparam logic [1:0] CHK_MODEL = 2'd1;
	localparam logic [1:0] CHK_FIXED = 2'd2;

	typedef struct packed {
		soc_pkg::op_t op;
		logic [soc_pkg::ADDR_W-1:0] addr;
		logic [soc_pkg::ARCH_W-1:0] wdata;
		logic [soc_pkg::SEL_W-1:0] sel;
		logic [soc_pkg::ARCH_W-1:0] exp;
		logic rnd;
		logic [1:0] chk;
		logic [2:0] grp;
	} vec_t;

	`include "tb_vectors.svh"

	logic clk;
	logic rst_p;
	soc_pkg::op_t pi1_op;
	logic [soc_pkg::ADDR_W-1:0] pi1_addr;
	logic [soc_pkg::ARCH_W-1:0] pi1_wdata;
	logic [soc_pkg::SEL_W-1:0] pi1_sel;
	logic [soc_pkg::ARCH_W-1:0] pi1_rdata;
	logic pi1_rdy;
	logic sys_rst;
	logic pwroff;

	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic [31:0] lcg_state = 32'hec2098be;
	// Expected RAM contents
	logic [31:0] ref_mem [1024];

	soc_top u_soc_top (
		.clk48mhz_i(clk),
		.rst_p(rst_p),
		.pi1_op_i(pi1_op),
		.pi1_addr_i(pi1_addr),
		.pi1_data_i(pi1_wdata),
		.pi1_sel_i(pi1_sel),
		.pi1_data_o(pi1_rdata),
		.pi1_rdy_o(pi1_rdy),
		.sys_rst_o(sys_rst),
		.pwroff_o(pwroff)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Byte lanes with sel set take the new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
		input logic [3:0] sel);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return res;
	endfunction

	function automatic string test_name(input logic [2:0] grp);
		case (grp)
			3'd2: return "RAM access";
			3'd3: return "swap";
			3'd4: return "device table";
			default: return "invalid device";
		endcase
	endfunction

	task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %0t ns: %s got %08h, expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: FAILED, %0d errors", tests_run, name, errors - err_start);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout at %0t ns: %s for %0d cycles", $time, what, WAIT_LIMIT);
		$display("RESULT: FAIL");
		$finish;
	endtask

	// Returns on a falling edge with ready high
	task automatic wait_ready();
		int n;
		n = 0;
		@(negedge clk);
		while (!pi1_rdy && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!pi1_rdy) begin
			abort_on_timeout("pi1_rdy_o stayed low");
		end
	endtask

	// Counts falling edges with sys_rst_o high starting at the next one
	task automatic measure_reset_pulse(output int cycles);
		logic done;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			if (sys_rst) begin
				cycles++;
			end else begin
				done = 1'b1;
			end
		end
		if (!done) begin
			abort_on_timeout("sys_rst_o stayed high");
		end else begin
			check_word("pi1_rdy_o after reset", 32'(pi1_rdy), 32'd1);
		end
	endtask

	// One access that returns on the falling edge after its accept edge
	task automatic issue_single(input soc_pkg::op_t op, input logic [29:0] addr,
		input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rdata);
		wait_ready();
		@(posedge clk);
		pi1_op <= op;
		pi1_addr <= addr;
		pi1_wdata <= wdata;
		pi1_sel <= sel;
		wait_ready();
		@(posedge clk);
		pi1_op <= soc_pkg::OP_NOOP;
		@(negedge clk);
		rdata = pi1_rdata;
	endtask

	// Rows go out back to back and each read is checked one cycle after its accept edge
	task automatic apply_table();
		vec_t row;
		vec_t prev;
		logic [31:0] wdata;
		logic [31:0] exp;
		logic [31:0] prev_exp;
		logic prev_chk;
		logic [2:0] next_grp;
		int idx;
		int err_start;
		prev_chk = 1'b0;
		prev_exp = '0;
		prev = '0;
		err_start = errors;
		wait_ready();
		for (int i = 0; i <= NUM_VECTORS; i++) begin
			@(posedge clk);
			if (i < NUM_VECTORS) begin
				row = VECTORS[i];
				next_grp = row.grp;
				wdata = row.rnd ? lcg_next() : row.wdata;
				idx = int'(row.addr - soc_pkg::RAM_BASE);
				exp = (row.chk == CHK_MODEL) ? ref_mem[idx] : row.exp;
				if ((row.op == soc_pkg::OP_WR || row.op == soc_pkg::OP_RW) &&
					(row.addr - soc_pkg::RAM_BASE) < soc_pkg::RAM_WORDS) begin
					ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, row.sel);
				end
				pi1_op <= row.op;
				pi1_addr <= row.addr;
				pi1_wdata <= wdata;
				pi1_sel <= row.sel;
			end else begin
				next_grp = 3'd0;
				pi1_op <= soc_pkg::OP_NOOP;
			end
			@(negedge clk);
			if (i > 0) begin
				if (prev_chk) begin
					check_word($sformatf("row %0d read at %08h", i - 1, prev.addr),
						pi1_rdata, prev_exp);
				end
				if (next_grp != prev.grp) begin
					report_test(test_name(prev.grp), err_start);
					err_start = errors;
				end
			end
			if (i < NUM_VECTORS) begin
				check_word($sformatf("pi1_rdy_o for row %0d", i), 32'(pi1_rdy), 32'd1);
				prev = row;
				prev_exp = exp;
				prev_chk = (row.chk != CHK_NONE);
			end
		end
	endtask

	task automatic request_reset(input string kind, input logic [31:0] ctl);
		logic [31:0] rdata;
		int cycles;
		issue_single(soc_pkg::OP_WR, soc_pkg::DEVTBL_BASE, ctl, 4'hf, rdata);
		check_word({kind, " sys_rst_o one cycle after accept"}, 32'(sys_rst), 32'd0);
		measure_reset_pulse(cycles);
		check_word({kind, " reset length"}, 32'(cycles), 32'(RST_CYCLES));
		issue_single(soc_pkg::OP_RD, 30'd5, 32'h0, 4'hf, rdata);
		check_word({kind, " reset keeps RAM word 5"}, rdata, ref_mem[5]);
	endtask

	initial begin
		int err_start;
		int cycles;
		logic [31:0] rdata;
		rst_p = 1'b1;
		pi1_op = soc_pkg::OP_NOOP;
		pi1_addr = '0;
		pi1_wdata = '0;
		pi1_sel = '0;

		// Power-on reset with rst_p seen by 8 rising edges
		err_start = errors;
		for (int c = 0; c < 7; c++) begin
			@(negedge clk);
			check_word("pi1_rdy_o during rst_p", 32'(pi1_rdy), 32'd0);
			check_word("sys_rst_o during rst_p", 32'(sys_rst), 32'd1);
			check_word("pwroff_o during rst_p", 32'(pwroff), 32'd0);
		end
		@(posedge clk);
		rst_p <= 1'b0;
		measure_reset_pulse(cycles);
		check_word("power-on reset length", 32'(cycles), 32'(RST_CYCLES));
		check_word("pwroff_o after power-on", 32'(pwroff), 32'd0);
		report_test("reset sequence", err_start);

		apply_table();

		err_start = errors;
		request_reset("warm", 32'h2);
		request_reset("cold", 32'h3);
		issue_single(soc_pkg::OP_WR, soc_pkg::DEVTBL_BASE, 32'h1, 4'hf, rdata);
		check_word("pwroff_o one cycle after accept", 32'(pwroff), 32'd0);
		// Power-off holds until rst_p
		for (int c = 0; c < 20; c++) begin
			@(negedge clk);
			check_word("pwroff_o after power-off", 32'(pwroff), 32'd1);
			check_word("pi1_rdy_o after power-off", 32'(pi1_rdy), 32'd0);
		end
		@(posedge clk);
		rst_p <= 1'b1;
		repeat (2) @(posedge clk);
		rst_p <= 1'b0;
		measure_reset_pulse(cycles);
		check_word("reset length after power-off", 32'(cycles), 32'(RST_CYCLES));
		check_word("pwroff_o after rst_p", 32'(pwroff), 32'd0);
		issue_single(soc_pkg::OP_RD, 30'd1023, 32'h0, 4'hf, rdata);
		check_word("RAM word 1023 after power-off", rdata, ref_mem[1023]);
		report_test("software resets", err_start);

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb.f
+incdir+sim
logic/soc_pkg.sv
logic/pi1_if.sv
logic/soc_rst_ctrl.sv
logic/pi1_fabric.sv
logic/soc_ram.sv
logic/soc_devtbl.sv
logic/soc_top.sv
sim/tb_soc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the SoC bus testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_soc_top -f tb.f -o tb_soc_top \
	|| { echo "Build failed"; exit 1; }

./obj_dir/tb_soc_top | tee /dev/stderr | grep -x "RESULT: PASS" > /dev/null \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
